//--- logic/sifhPkg.sv
package sifhPkg;

    localparam int NP              = 12;   // sample width
    localparam int NB              = 6;    // bin address width
    localparam int BIN_NUM_PER_HIS = 64;   // bins per pixel and pass
    localparam int PIXEL_NUM       = 4;
    localparam int DATA_NUM        = 4;    // samples per pixel per acquisition
    localparam int ACQ_NUM         = 8;    // acquisitions per pass
    localparam int PEAK_MAX        = 8;    // count width
    localparam int BIN_NUM_PER_RAM = PIXEL_NUM * BIN_NUM_PER_HIS;
    localparam int SETTLE_CYCLES   = 2;    // gap after a pass

    // sample and bin widths
    typedef logic [NP-1:0] sampleT;
    typedef logic [NB-1:0] binAddrT;

    typedef logic [PEAK_MAX-1:0] countT;

    typedef logic [$clog2(PIXEL_NUM)-1:0] pixelIdxT;
    typedef logic [$clog2(BIN_NUM_PER_RAM)-1:0] memAddrT;   // pixel base plus bin

    // pass sequencing
    typedef enum logic [2:0] {
        COARSE,
        COARSE_SETTLE,
        FINE,
        FINE_SETTLE,
        READOUT
    } seqStateT;

endpackage

//--- logic/acqSequencer.sv
`timescale 1ns/10ps

module acqSequencer (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    output logic              sampleAccept,
    output sifhPkg::pixelIdxT pixelIdx,
    output logic              hisNum,
    output logic              passClear,
    output logic              windowLoad,
    output logic              acqFinish,
    output logic              peakDone,
    output logic              readEn,
    output sifhPkg::pixelIdxT readIdx
);

    sifhPkg::seqStateT state;

    logic [$clog2(sifhPkg::DATA_NUM)-1:0]        inputCnt;
    logic [$clog2(sifhPkg::ACQ_NUM)-1:0]         acqCnt;
    logic [$clog2(sifhPkg::SETTLE_CYCLES+1)-1:0] settleCnt;
    logic lastSample;
    logic settleDone;
    logic readDone;

    // samples only taken in a pass, never on its clear cycle
    assign sampleAccept = wrEn && !passClear &&
                          (state == sifhPkg::COARSE || state == sifhPkg::FINE);

    assign lastSample = sampleAccept &&
                        (inputCnt == sifhPkg::DATA_NUM - 1) &&
                        (pixelIdx == sifhPkg::PIXEL_NUM - 1) &&
                        (acqCnt == sifhPkg::ACQ_NUM - 1);

    assign settleDone = (settleCnt == sifhPkg::SETTLE_CYCLES - 1);
    assign readDone   = (readIdx == sifhPkg::PIXEL_NUM - 1);
    assign windowLoad = (state == sifhPkg::COARSE_SETTLE) && settleDone;
    assign readEn     = (state == sifhPkg::READOUT);

    // nested input / pixel / acquisition counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            inputCnt <= '0;
            pixelIdx <= '0;
            acqCnt   <= '0;
        end else if (sampleAccept) begin
            if (inputCnt == sifhPkg::DATA_NUM - 1) begin
                inputCnt <= '0;
                if (pixelIdx == sifhPkg::PIXEL_NUM - 1) begin
                    pixelIdx <= '0;
                    if (acqCnt == sifhPkg::ACQ_NUM - 1) begin
                        acqCnt <= '0;   // pass complete
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelIdx <= pixelIdx + 1'b1;
                end
            end else begin
                inputCnt <= inputCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= sifhPkg::COARSE;
            hisNum    <= 1'b0;
            passClear <= 1'b0;
            peakDone  <= 1'b0;
            acqFinish <= 1'b0;
            settleCnt <= '0;
            readIdx   <= '0;
        end else begin
            passClear <= 1'b0;
            peakDone  <= 1'b0;
            acqFinish <= lastSample;   // one cycle after the final sample
            case (state)
                sifhPkg::COARSE: begin
                    if (lastSample) begin
                        state     <= sifhPkg::COARSE_SETTLE;
                        settleCnt <= '0;
                    end
                end
                sifhPkg::COARSE_SETTLE: begin
                    if (settleDone) begin
                        state     <= sifhPkg::FINE;
                        hisNum    <= 1'b1;
                        passClear <= 1'b1;
                        peakDone  <= 1'b1;
                    end else begin
                        settleCnt <= settleCnt + 1'b1;
                    end
                end
                sifhPkg::FINE: begin
                    if (lastSample) begin
                        state     <= sifhPkg::FINE_SETTLE;
                        settleCnt <= '0;
                    end
                end
                sifhPkg::FINE_SETTLE: begin
                    if (settleDone) begin
                        state   <= sifhPkg::READOUT;
                        readIdx <= '0;
                    end else begin
                        settleCnt <= settleCnt + 1'b1;
                    end
                end
                sifhPkg::READOUT: begin
                    if (readDone) begin
                        state     <= sifhPkg::COARSE;   // back to a fresh coarse pass
                        hisNum    <= 1'b0;
                        passClear <= 1'b1;
                    end else begin
                        readIdx <= readIdx + 1'b1;
                    end
                end
                default: state <= sifhPkg::COARSE;
            endcase
        end
    end

    // a strobe on a clear cycle would be dropped
    clearNoAccept: assert property (@(posedge clk) disable iff (!combin_res)
        passClear |-> !wrEn);

    // source must hold off while settling or reading out
    wrEnInPass: assert property (@(posedge clk) disable iff (!combin_res)
        wrEn |-> (state == sifhPkg::COARSE || state == sifhPkg::FINE))
        else $warning("wrEn high outside a pass, sample ignored");

endmodule

//--- logic/sampleWindow.sv
`timescale 1ns/10ps

module sampleWindow (
    input  logic                                        clk,
    input  logic                                        combin_res,
    input  sifhPkg::sampleT                             data,
    input  sifhPkg::pixelIdxT                           pixelIdx,
    input  logic                                        sampleAccept,
    input  logic                                        hisNum,
    input  logic                                        windowLoad,
    input  logic [sifhPkg::PIXEL_NUM*sifhPkg::NB-1:0]   coarsePeak,
    output sifhPkg::memAddrT                            memAddr,
    output sifhPkg::binAddrT                            binAddr,
    output logic                                        binHit
);

    sifhPkg::sampleT winStart [sifhPkg::PIXEL_NUM];   // fine window start per pixel
    sifhPkg::sampleT curStart;
    sifhPkg::sampleT offset;
    logic            inWindow;

    // window placed half a window below the coarse peak, kept inside the sample range
    function automatic sifhPkg::sampleT clampStart(input sifhPkg::binAddrT peakBin);
        sifhPkg::sampleT centre;
        sifhPkg::sampleT maxStart;
        centre   = sifhPkg::sampleT'(peakBin) << (sifhPkg::NP - sifhPkg::NB);
        maxStart = sifhPkg::sampleT'((1 << sifhPkg::NP) - sifhPkg::BIN_NUM_PER_HIS);
        if (centre < sifhPkg::sampleT'(sifhPkg::BIN_NUM_PER_HIS / 2)) begin
            clampStart = '0;   // low end clamp
        end else begin
            clampStart = centre - sifhPkg::sampleT'(sifhPkg::BIN_NUM_PER_HIS / 2);
            if (clampStart > maxStart) begin
                clampStart = maxStart;   // high end clamp
            end
        end
    endfunction

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                winStart[p] <= '0;
            end
        end else if (windowLoad) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                winStart[p] <= clampStart(coarsePeak[p*sifhPkg::NB +: sifhPkg::NB]);
            end
        end
    end

    always_comb begin
        curStart = winStart[pixelIdx];
        offset   = data - curStart;
        inWindow = (data >= curStart) && (offset < sifhPkg::BIN_NUM_PER_HIS);
        if (!hisNum) begin
            binAddr = data[sifhPkg::NP-1 -: sifhPkg::NB];   // top bits only
            binHit  = sampleAccept;
        end else begin
            binAddr = offset[sifhPkg::NB-1:0];   // one unit per bin
            binHit  = sampleAccept && inWindow;
        end
    end

    assign memAddr = {pixelIdx, binAddr};

endmodule

//--- logic/histogramMemory.sv
`timescale 1ns/10ps

module histogramMemory (
    input  logic              clk,
    input  logic              combin_res,
    input  sifhPkg::memAddrT  memAddr,
    input  sifhPkg::binAddrT  binAddr,
    input  sifhPkg::pixelIdxT pixelIdx,
    input  logic              binHit,
    input  logic              passClear,
    output sifhPkg::countT    binCounts,
    output logic              countStrobe,
    output sifhPkg::binAddrT  binAddrQ,
    output sifhPkg::pixelIdxT pixelIdxQ
);

    sifhPkg::countT countMem [sifhPkg::BIN_NUM_PER_RAM];
    logic [sifhPkg::BIN_NUM_PER_RAM-1:0] validBits;   // entry written this pass

    sifhPkg::memAddrT wrAddr;
    logic             wrPend;   // write of binCounts still to land
    sifhPkg::countT   oldCount;
    sifhPkg::countT   newCount;

    always_comb begin
        if (wrPend && (wrAddr == memAddr)) begin
            oldCount = binCounts;   // forward pending write
        end else if (validBits[memAddr]) begin
            oldCount = countMem[memAddr];
        end else begin
            oldCount = '0;
        end
        newCount = oldCount + 1'b1;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validBits   <= '0;
            wrPend      <= 1'b0;
            binCounts   <= '0;
            countStrobe <= 1'b0;
        end else begin
            countStrobe <= binHit;
            wrPend      <= binHit;
            if (binHit) begin
                binCounts <= newCount;   // holds on dropped samples
            end
            if (passClear) begin
                validBits <= '0;   // whole histogram empty in one cycle
            end else if (wrPend) begin
                validBits[wrAddr] <= 1'b1;
            end
        end
    end

    // second pipeline stage, write back of the new count
    always_ff @(posedge clk) begin
        wrAddr    <= memAddr;
        binAddrQ  <= binAddr;
        pixelIdxQ <= pixelIdx;
        if (wrPend && !passClear) begin
            countMem[wrAddr] <= binCounts;
        end
    end

    noCountWrap: assert property (@(posedge clk) disable iff (!combin_res)
        countStrobe |-> (binCounts != '0));

endmodule

//--- logic/peakTracker.sv
`timescale 1ns/10ps

module peakTracker (
    input  logic                                        clk,
    input  logic                                        combin_res,
    input  logic                                        countStrobe,
    input  sifhPkg::countT                              binCounts,
    input  sifhPkg::binAddrT                            binAddrQ,
    input  sifhPkg::pixelIdxT                           pixelIdxQ,
    input  logic                                        passClear,
    input  logic                                        hisNum,
    input  logic                                        readEn,
    input  sifhPkg::pixelIdxT                           readIdx,
    output logic [sifhPkg::PIXEL_NUM*sifhPkg::NB-1:0]   coarsePeak,
    output logic                                        resultValid,
    output sifhPkg::pixelIdxT                           resultPixel,
    output sifhPkg::binAddrT                            peakCH,
    output sifhPkg::binAddrT                            peakFH
);

    sifhPkg::countT   runMax    [sifhPkg::PIXEL_NUM];   // running maximum count
    sifhPkg::binAddrT runBin    [sifhPkg::PIXEL_NUM];   // bin that first reached it
    sifhPkg::binAddrT coarseBin [sifhPkg::PIXEL_NUM];   // frozen once fine pass starts
    logic             newPeak;

    // strictly greater, so a tie keeps the earlier bin
    assign newPeak = countStrobe && (binCounts > runMax[pixelIdxQ]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                runMax[p]    <= '0;
                runBin[p]    <= '0;
                coarseBin[p] <= '0;
            end
        end else if (passClear) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
                if (!hisNum) begin
                    coarseBin[p] <= '0;   // new frame
                end
            end
        end else if (newPeak) begin
            runMax[pixelIdxQ] <= binCounts;
            runBin[pixelIdxQ] <= binAddrQ;
            if (!hisNum) begin
                coarseBin[pixelIdxQ] <= binAddrQ;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            coarsePeak[p*sifhPkg::NB +: sifhPkg::NB] = coarseBin[p];
        end
    end

    // readout straight from the trackers
    assign resultValid = readEn;
    assign resultPixel = readIdx;
    assign peakCH      = readEn ? coarseBin[readIdx] : '0;
    assign peakFH      = readEn ? runBin[readIdx] : '0;   // fine pass result

endmodule

//--- logic/hisBuilderTop.sv
`timescale 1ns/10ps

module hisBuilderTop (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    input  sifhPkg::sampleT   data,
    output sifhPkg::countT    binCounts,
    output logic              hisNum,
    output logic              acqFinish,
    output logic              peakDone,
    output logic              resultValid,
    output sifhPkg::pixelIdxT resultPixel,
    output sifhPkg::binAddrT  peakCH,
    output sifhPkg::binAddrT  peakFH
);

    logic              sampleAccept;
    sifhPkg::pixelIdxT pixelIdx;
    logic              passClear;
    logic              windowLoad;
    logic              readEn;
    sifhPkg::pixelIdxT readIdx;

    sifhPkg::memAddrT  memAddr;
    sifhPkg::binAddrT  binAddr;
    logic              binHit;

    logic              countStrobe;
    sifhPkg::binAddrT  binAddrQ;
    sifhPkg::pixelIdxT pixelIdxQ;   // pixel aligned with binCounts

    logic [sifhPkg::PIXEL_NUM*sifhPkg::NB-1:0] coarsePeak;

    acqSequencer seq (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .sampleAccept (sampleAccept),
        .pixelIdx     (pixelIdx),
        .hisNum       (hisNum),
        .passClear    (passClear),
        .windowLoad   (windowLoad),
        .acqFinish    (acqFinish),
        .peakDone     (peakDone),
        .readEn       (readEn),
        .readIdx      (readIdx)
    );

    sampleWindow win (
        .clk          (clk),
        .combin_res   (combin_res),
        .data         (data),
        .pixelIdx     (pixelIdx),
        .sampleAccept (sampleAccept),
        .hisNum       (hisNum),
        .windowLoad   (windowLoad),
        .coarsePeak   (coarsePeak),
        .memAddr      (memAddr),
        .binAddr      (binAddr),
        .binHit       (binHit)
    );

    histogramMemory mem (
        .clk         (clk),
        .combin_res  (combin_res),
        .memAddr     (memAddr),
        .binAddr     (binAddr),
        .pixelIdx    (pixelIdx),
        .binHit      (binHit),
        .passClear   (passClear),
        .binCounts   (binCounts),
        .countStrobe (countStrobe),
        .binAddrQ    (binAddrQ),
        .pixelIdxQ   (pixelIdxQ)
    );

    peakTracker peak (
        .clk         (clk),
        .combin_res  (combin_res),
        .countStrobe (countStrobe),
        .binCounts   (binCounts),
        .binAddrQ    (binAddrQ),
        .pixelIdxQ   (pixelIdxQ),
        .passClear   (passClear),
        .hisNum      (hisNum),
        .readEn      (readEn),
        .readIdx     (readIdx),
        .coarsePeak  (coarsePeak),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .peakCH      (peakCH),
        .peakFH      (peakFH)
    );

endmodule

//--- verif/hisBuilderChecker.sv
`timescale 1ns/10ps

module hisBuilderChecker (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    input  sifhPkg::sampleT   data,
    input  sifhPkg::countT    binCounts,
    input  logic              hisNum,
    input  logic              acqFinish,
    input  logic              peakDone,
    input  logic              resultValid,
    input  sifhPkg::pixelIdxT resultPixel,
    input  sifhPkg::binAddrT  peakCH,
    input  sifhPkg::binAddrT  peakFH,
    output int                errorCount,
    output int                resultCount,
    output int                finishCount
);

    sifhPkg::seqStateT mState;   // model of the pass sequence
    int mCount [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM_PER_HIS];
    int mMax [sifhPkg::PIXEL_NUM];
    int mBin [sifhPkg::PIXEL_NUM];   // bin that first reached mMax
    int mCoarse [sifhPkg::PIXEL_NUM];
    int winStart [sifhPkg::PIXEL_NUM];
    int inCnt, pixCnt, acqCnt;
    int settleCnt, readIdx, expCount;
    logic mClear, mHis, mFinish, mDone;

    // window half a window below the coarse bin edge, inside the sample range
    function automatic int windowStart(input int peakBin);
        int s;
        s = peakBin * sifhPkg::BIN_NUM_PER_HIS - sifhPkg::BIN_NUM_PER_HIS / 2;
        if (s < 0) s = 0;
        if (s > (1 << sifhPkg::NP) - sifhPkg::BIN_NUM_PER_HIS)
            s = (1 << sifhPkg::NP) - sifhPkg::BIN_NUM_PER_HIS;
        return s;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic clearPass();
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            for (int b = 0; b < sifhPkg::BIN_NUM_PER_HIS; b++) mCount[p][b] = 0;
            mMax[p] = 0;
            mBin[p] = 0;
        end
    endtask

    task automatic stepModel();
        int   p;
        int   b;
        logic hit;
        logic accept;
        logic last;
        if (mClear) clearPass();
        accept = wrEn && !mClear && (mState == sifhPkg::COARSE || mState == sifhPkg::FINE);
        last   = accept && inCnt == sifhPkg::DATA_NUM - 1 && pixCnt == sifhPkg::PIXEL_NUM - 1 &&
                 acqCnt == sifhPkg::ACQ_NUM - 1;
        if (accept) begin
            p = pixCnt;
            if (mState == sifhPkg::COARSE) begin
                b   = data >> (sifhPkg::NP - sifhPkg::NB);   // top bits
                hit = 1'b1;
            end else begin
                b   = int'(data) - winStart[p];
                hit = (b >= 0) && (b < sifhPkg::BIN_NUM_PER_HIS);
            end
            if (hit) begin
                mCount[p][b]++;
                expCount = mCount[p][b];
                if (mCount[p][b] > mMax[p]) begin   // strictly greater keeps first bin
                    mMax[p] = mCount[p][b];
                    mBin[p] = b;
                end
            end
            inCnt++;
            if (inCnt == sifhPkg::DATA_NUM) begin
                inCnt = 0;
                pixCnt++;
                if (pixCnt == sifhPkg::PIXEL_NUM) begin
                    pixCnt = 0;
                    acqCnt = (acqCnt + 1) % sifhPkg::ACQ_NUM;
                end
            end
        end
        mFinish = last;
        mDone   = 1'b0;
        mClear  = 1'b0;
        case (mState)
            sifhPkg::COARSE: if (last) begin
                mState    = sifhPkg::COARSE_SETTLE;
                settleCnt = 0;
            end
            sifhPkg::COARSE_SETTLE: if (settleCnt == sifhPkg::SETTLE_CYCLES - 1) begin
                mState = sifhPkg::FINE;
                mHis   = 1'b1;
                mClear = 1'b1;
                mDone  = 1'b1;
                for (int q = 0; q < sifhPkg::PIXEL_NUM; q++) begin
                    mCoarse[q]  = mBin[q];
                    winStart[q] = windowStart(mBin[q]);
                end
            end else settleCnt++;
            sifhPkg::FINE: if (last) begin
                mState    = sifhPkg::FINE_SETTLE;
                settleCnt = 0;
            end
            sifhPkg::FINE_SETTLE: if (settleCnt == sifhPkg::SETTLE_CYCLES - 1) begin
                mState  = sifhPkg::READOUT;
                readIdx = 0;
            end else settleCnt++;
            default: if (readIdx == sifhPkg::PIXEL_NUM - 1) begin
                mState = sifhPkg::COARSE;   // next frame
                mHis   = 1'b0;
                mClear = 1'b1;
            end else readIdx++;
        endcase
    endtask

    initial begin
        errorCount  = 0;
        resultCount = 0;
        finishCount = 0;
    end

    always @(posedge clk) begin
        if (!combin_res) begin
            mState    = sifhPkg::COARSE;
            {inCnt, pixCnt, acqCnt, settleCnt, readIdx, expCount} = '0;
            {mClear, mHis, mFinish, mDone} = '0;
            clearPass();
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                mCoarse[p]  = 0;
                winStart[p] = 0;
            end
        end else begin
            compareValue("binCounts", binCounts, expCount);
            compareValue("hisNum", hisNum, mHis);
            compareValue("acqFinish", acqFinish, mFinish);
            compareValue("peakDone", peakDone, mDone);
            compareValue("resultValid", resultValid, mState == sifhPkg::READOUT);
            if (mState == sifhPkg::READOUT) begin
                compareValue("resultPixel", resultPixel, readIdx);
                compareValue("peakCH", peakCH, mCoarse[readIdx]);
                compareValue("peakFH", peakFH, mBin[readIdx]);
            end
            if (resultValid === 1'b1) resultCount++;
            if (acqFinish === 1'b1) finishCount++;
            stepModel();
        end
    end

endmodule

//--- verif/hisBuilderTb.sv
`timescale 1ns/10ps

module hisBuilderTb;

    logic              clk;
    logic              combin_res;
    logic              wrEn;
    sifhPkg::sampleT   data;
    sifhPkg::countT    binCounts;
    logic              hisNum;
    logic              acqFinish;
    logic              peakDone;
    logic              resultValid;
    sifhPkg::pixelIdxT resultPixel;
    sifhPkg::binAddrT  peakCH;
    sifhPkg::binAddrT  peakFH;
    int                errorCount;
    int                resultCount;
    int                finishCount;
    integer            seed;
    logic              timedOut;
    int                centre [sifhPkg::PIXEL_NUM];   // cluster centre per pixel

    hisBuilderTop uut (.*);

    hisBuilderChecker chk (.*);

    always #2 clk = ~clk;   // 4 ns period

    // mostly clustered around the centre, sometimes anywhere
    function automatic int pickSample(input int mid, input int spread);
        int v;
        if (($random(seed) & 7) == 0) v = $random(seed) & ((1 << sifhPkg::NP) - 1);
        else v = mid + ($random(seed) % spread);
        if (v < 0) v = 0;
        if (v > (1 << sifhPkg::NP) - 1) v = (1 << sifhPkg::NP) - 1;
        return v;
    endfunction

    task automatic pickCentres(input int frame);
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            if (frame == 1) centre[p] = (p % 2) ? 4085 - 30 * p : 12 + 30 * p;   // range ends
            else centre[p] = 200 + $unsigned($random(seed)) % 3700;
        end
    endtask

    task automatic sendSample(input int value);
        int gap;
        @(negedge clk);
        wrEn = 1'b1;
        data = sifhPkg::sampleT'(value);
        gap  = $unsigned($random(seed)) % 3;   // zero gap gives back-to-back strobes
        repeat (gap) begin
            @(negedge clk);
            wrEn = 1'b0;
            data = sifhPkg::sampleT'($random(seed));
        end
    endtask

    task automatic runPass(input int spread);
        for (int a = 0; a < sifhPkg::ACQ_NUM; a++)
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++)
                for (int k = 0; k < sifhPkg::DATA_NUM; k++)
                    sendSample(pickSample(centre[p], spread));
    endtask

    // stray strobes while waiting, the DUT has to ignore them
    task automatic waitFor(input int sel, input logic level, input string what, input int limit);
        int   n;
        logic sig;
        n   = 0;
        sig = ~level;
        while (sig !== level && !timedOut) begin
            @(negedge clk);
            case (sel)
                0:       sig = peakDone;
                1:       sig = resultValid;
                default: sig = hisNum;
            endcase
            wrEn = (sig !== level) && (($random(seed) & 3) == 0);
            data = sifhPkg::sampleT'($random(seed));
            n++;
            if (sig !== level && n >= limit) begin
                $display("timeout: %s did not happen within %0d cycles", what, limit);
                timedOut = 1'b1;
                wrEn     = 1'b0;
            end
        end
    endtask

    initial begin
        seed       = 32'h5aa704f7;
        clk        = 1'b0;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        timedOut   = 1'b0;
        repeat (10) @(negedge clk);
        combin_res = 1'b1;
        for (int frame = 0; frame < 3 && !timedOut; frame++) begin
            pickCentres(frame);
            runPass(24);
            waitFor(0, 1'b1, "peakDone", 50);
            if (!timedOut) runPass(48);   // wider spread, some samples miss the window
            waitFor(1, 1'b1, "readout start", 50);
            waitFor(1, 1'b0, "readout end", 50);
            waitFor(2, 1'b0, "hisNum fall", 50);
        end
        repeat (4) @(negedge clk);
        if (!timedOut && resultCount != 3 * sifhPkg::PIXEL_NUM)
            $display("wrong number of readout cycles: %0d", resultCount);
        if (!timedOut && finishCount != 6)
            $display("wrong number of acqFinish pulses: %0d", finishCount);
        $display("value errors %0d, timeouts %0d, readout cycles %0d, acqFinish pulses %0d",
                 errorCount, timedOut, resultCount, finishCount);
        if (errorCount == 0 && !timedOut && resultCount == 3 * sifhPkg::PIXEL_NUM &&
            finishCount == 6) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
logic/sifhPkg.sv
logic/acqSequencer.sv
logic/sampleWindow.sv
logic/histogramMemory.sv
logic/peakTracker.sv
logic/hisBuilderTop.sv
verif/hisBuilderChecker.sv
verif/hisBuilderTb.sv
